//--- design/keypad_params.svh
`ifndef KEYPAD_PARAMS_SVH
`define KEYPAD_PARAMS_SVH

// keypad matrix size
`define KP_ROWS 4
`define KP_COLS 4

// cycles each column stays driven, one sweep is KP_COLS times this
`define KP_SCAN_DWELL 4
// identical sweeps in a row before a key counts as pressed
`define KP_DEBOUNCE_SWEEPS 2

// message buffer geometry
`define MSG_CHARS 16
`define CHAR_W 8
// ascii space, used for reset fill and delete fill
`define SPACE_CHAR 8'h20

`endif

//--- design/keypad_pkg.sv
`include "keypad_params.svh"

package keypad_pkg;

  // one-hot row in the upper nibble, one-hot column in the lower nibble
  typedef struct packed {
    logic [`KP_ROWS-1:0] row;
    logic [`KP_COLS-1:0] col;
  } key_code_t;

  // multi-tap index into a key's symbol list
  typedef logic [1:0] tap_count_t;

  // operations handed from the tap tracker to the assembler
  typedef enum logic [1:0] {
    OP_CHAR,
    OP_SPACE,
    OP_DELETE,
    OP_SEND
  } entry_op_t;

  // whole message, newest character in the low byte
  typedef logic [`MSG_CHARS*`CHAR_W-1:0] msg_t;

  // key codes of the 4x4 pad
  localparam key_code_t KEY_1    = 8'b0001_0001;
  localparam key_code_t KEY_2    = 8'b0001_0010;
  localparam key_code_t KEY_3    = 8'b0001_0100;
  localparam key_code_t KEY_A    = 8'b0001_1000;
  localparam key_code_t KEY_4    = 8'b0010_0001;
  localparam key_code_t KEY_5    = 8'b0010_0010;
  localparam key_code_t KEY_6    = 8'b0010_0100;
  localparam key_code_t KEY_B    = 8'b0010_1000;
  localparam key_code_t KEY_7    = 8'b0100_0001;
  localparam key_code_t KEY_8    = 8'b0100_0010;
  localparam key_code_t KEY_9    = 8'b0100_0100;
  localparam key_code_t KEY_C    = 8'b0100_1000;
  localparam key_code_t KEY_STAR = 8'b1000_0001;
  localparam key_code_t KEY_0    = 8'b1000_0010;
  localparam key_code_t KEY_HASH = 8'b1000_0100;
  localparam key_code_t KEY_D    = 8'b1000_1000;

endpackage

//--- design/key_entry_if.sv
`timescale 1ns/1ps

// committed entry operations, tap tracker to message assembler
interface key_entry_if;

  // one-cycle strobe, the other fields only count while it is high
  logic                   valid;
  keypad_pkg::entry_op_t  op;
  // key and tap index of the character, used by OP_CHAR only
  keypad_pkg::key_code_t  key;
  keypad_pkg::tap_count_t count;

  // no back-pressure, the sink takes every entry as it comes
  modport source (
    output valid, op, key, count
  );

  modport sink (
    input valid, op, key, count
  );

endinterface

//--- design/keypad_scanner.sv
`timescale 1ns/1ps
`include "keypad_params.svh"

module keypad_scanner
  import keypad_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`KP_ROWS-1:0] readrow,
  output logic [`KP_COLS-1:0] scancol,
  output logic                key_press,
  output key_code_t           key_code
);

  localparam int DWELL_W  = $clog2(`KP_SCAN_DWELL);
  localparam int STABLE_W = $clog2(`KP_DEBOUNCE_SWEEPS + 1);

  logic [DWELL_W-1:0]  dwell_cnt;
  logic                dwell_last;
  logic                sweep_end;
  // hits seen this sweep: 0 none, 1 single key, 2 more than one
  logic [1:0]          hit_cnt;
  logic [1:0]          hit_cnt_nxt;
  key_code_t           hit_code;
  key_code_t           hit_code_nxt;
  logic                last_valid;
  key_code_t           last_code;
  logic [STABLE_W-1:0] stable_cnt;
  logic [STABLE_W-1:0] stable_nxt;
  logic                armed;
  logic                fire;

  // rows are sampled in the last cycle a column is driven
  assign dwell_last = (dwell_cnt == DWELL_W'(`KP_SCAN_DWELL - 1));
  assign sweep_end  = dwell_last && scancol[`KP_COLS-1];

  // fold the current row sample into the sweep accumulator
  always_comb begin
    hit_cnt_nxt  = hit_cnt;
    hit_code_nxt = hit_code;
    if (readrow != '0) begin
      if ($onehot(readrow) && hit_cnt == 2'd0) begin
        hit_cnt_nxt  = 2'd1;
        hit_code_nxt = '{row: readrow, col: scancol};
      end else begin
        // second hit or several rows at once, sweep gives no key
        hit_cnt_nxt = 2'd2;
      end
    end
  end

  // count identical single-key sweeps, saturating at the debounce limit
  always_comb begin
    stable_nxt = '0;
    if (hit_cnt_nxt == 2'd1) begin
      if (last_valid && hit_code_nxt == last_code) begin
        if (stable_cnt == STABLE_W'(`KP_DEBOUNCE_SWEEPS))
          stable_nxt = stable_cnt;
        else
          stable_nxt = stable_cnt + 1'b1;
      end else begin
        stable_nxt = STABLE_W'(1);
      end
    end
  end

  assign fire = sweep_end && armed && (stable_nxt == STABLE_W'(`KP_DEBOUNCE_SWEEPS));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dwell_cnt  <= '0;
      scancol    <= `KP_COLS'(1);
      hit_cnt    <= 2'd0;
      last_valid <= 1'b0;
      stable_cnt <= '0;
      armed      <= 1'b1;
      key_press  <= 1'b0;
    end else begin
      key_press <= 1'b0;
      dwell_cnt <= dwell_last ? '0 : dwell_cnt + 1'b1;
      if (dwell_last)
        scancol <= {scancol[`KP_COLS-2:0], scancol[`KP_COLS-1]};
      if (sweep_end) begin
        hit_cnt    <= 2'd0;
        last_valid <= (hit_cnt_nxt == 2'd1);
        stable_cnt <= stable_nxt;
        // a fully idle sweep means the key was let go
        if (hit_cnt_nxt == 2'd0)
          armed <= 1'b1;
        else if (fire) begin
          key_press <= 1'b1;
          armed     <= 1'b0;
        end
      end else if (dwell_last) begin
        hit_cnt <= hit_cnt_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dwell_last)
      hit_code <= hit_code_nxt;
    if (sweep_end)
      last_code <= hit_code_nxt;
    if (fire)
      key_code <= hit_code_nxt;
  end

endmodule

//--- design/mode_control.sv
`timescale 1ns/1ps

module mode_control
  import keypad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      key_press,
  input  key_code_t key_code,
  output logic      letter_mode,
  output logic      upper
);

  // B flips between number and letter entry
  // # is shift, but only means that in letter mode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      letter_mode <= 1'b0;
      upper       <= 1'b0;
    end else if (key_press) begin
      if (key_code == KEY_B) begin
        letter_mode <= !letter_mode;
        // shift never survives a mode change
        upper       <= 1'b0;
      end else if (key_code == KEY_HASH && letter_mode) begin
        upper <= !upper;
      end
    end
  end

endmodule

//--- design/tap_tracker.sv
`timescale 1ns/1ps

module tap_tracker
  import keypad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      key_press,
  input  key_code_t key_code,
  input  logic      letter_mode,
  key_entry_if.source entry
);

  logic       mode_q;
  logic       pend_valid;
  logic       pend_valid_nxt;
  key_code_t  pend_key;
  key_code_t  pend_key_nxt;
  tap_count_t pend_count;
  tap_count_t pend_count_nxt;
  logic       emit;
  entry_op_t  emit_op;
  key_code_t  emit_key;
  tap_count_t emit_count;

  // highest tap index, keys with four symbols wrap after 3
  function automatic tap_count_t last_tap(key_code_t k);
    if (k == KEY_1 || k == KEY_7 || k == KEY_9 || k == KEY_0 || k == KEY_STAR)
      return 2'd3;
    return 2'd2;
  endfunction

  always_comb begin
    emit           = 1'b0;
    emit_op        = OP_CHAR;
    emit_key       = key_code;
    emit_count     = '0;
    pend_valid_nxt = pend_valid;
    pend_key_nxt   = pend_key;
    pend_count_nxt = pend_count;
    if (key_press) begin
      case (key_code)
        KEY_A: begin
          emit           = 1'b1;
          emit_op        = OP_DELETE;
          pend_valid_nxt = 1'b0;
        end
        KEY_D: begin
          emit           = 1'b1;
          emit_op        = OP_SEND;
          pend_valid_nxt = 1'b0;
        end
        KEY_C: begin
          emit = 1'b1;
          // confirm the pending letter, space when nothing waits
          if (pend_valid) begin
            emit_key       = pend_key;
            emit_count     = pend_count;
            pend_valid_nxt = 1'b0;
          end else begin
            emit_op = OP_SPACE;
          end
        end
        // mode toggle is handled by mode_control
        KEY_B: begin
        end
        // shift in letter mode, plain '#' in number mode
        KEY_HASH: emit = !letter_mode;
        default: begin
          if (!letter_mode) begin
            emit = 1'b1;
          end else if (pend_valid && key_code == pend_key) begin
            // same key again, step to its next symbol
            if (pend_count == last_tap(pend_key))
              pend_count_nxt = '0;
            else
              pend_count_nxt = pend_count + 1'b1;
          end else begin
            // different key commits the old letter and starts a new one
            emit           = pend_valid;
            emit_key       = pend_key;
            emit_count     = pend_count;
            pend_valid_nxt = 1'b1;
            pend_key_nxt   = key_code;
            pend_count_nxt = '0;
          end
        end
      endcase
    end
    // a pending letter is dropped when the mode flips under it
    if (letter_mode != mode_q)
      pend_valid_nxt = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry.valid <= 1'b0;
      pend_valid  <= 1'b0;
      mode_q      <= 1'b0;
    end else begin
      entry.valid <= emit;
      pend_valid  <= pend_valid_nxt;
      mode_q      <= letter_mode;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      entry.op    <= emit_op;
      entry.key   <= emit_key;
      entry.count <= emit_count;
    end
    pend_key   <= pend_key_nxt;
    pend_count <= pend_count_nxt;
  end

endmodule

//--- design/message_assembler.sv
`timescale 1ns/1ps
`include "keypad_params.svh"

module message_assembler
  import keypad_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      letter_mode,
  input  logic      upper,
  key_entry_if.sink entry,
  output msg_t      msg,
  output logic      msg_tx_ctrl
);

  localparam int MSG_W = `MSG_CHARS * `CHAR_W;

  // symbol sets of the non-letter keys, tap 0 in the top byte
  localparam logic [4*`CHAR_W-1:0] SYMS_1    = "@_&:";
  localparam logic [4*`CHAR_W-1:0] SYMS_STAR = "+-/=";
  localparam logic [4*`CHAR_W-1:0] SYMS_0    = ",.?!";

  logic [`CHAR_W-1:0] letter_base;
  logic [`CHAR_W-1:0] sym;

  function automatic logic [`CHAR_W-1:0] pick_sym(logic [4*`CHAR_W-1:0] set, tap_count_t n);
    return set[(3 - int'(n)) * `CHAR_W +: `CHAR_W];
  endfunction

  // first lower-case letter of each letter key, zero for the others
  always_comb begin
    case (entry.key)
      KEY_2:   letter_base = "a";
      KEY_3:   letter_base = "d";
      KEY_4:   letter_base = "g";
      KEY_5:   letter_base = "j";
      KEY_6:   letter_base = "m";
      KEY_7:   letter_base = "p";
      KEY_8:   letter_base = "t";
      KEY_9:   letter_base = "w";
      default: letter_base = '0;
    endcase
  end

  // character for an OP_CHAR entry
  always_comb begin
    sym = `SPACE_CHAR;
    if (!letter_mode) begin
      case (entry.key)
        KEY_1:    sym = "1";
        KEY_2:    sym = "2";
        KEY_3:    sym = "3";
        KEY_4:    sym = "4";
        KEY_5:    sym = "5";
        KEY_6:    sym = "6";
        KEY_7:    sym = "7";
        KEY_8:    sym = "8";
        KEY_9:    sym = "9";
        KEY_0:    sym = "0";
        KEY_STAR: sym = "*";
        KEY_HASH: sym = "#";
        default:  sym = `SPACE_CHAR;
      endcase
    end else if (letter_base != '0) begin
      // letters within a key are consecutive in ascii
      sym = letter_base + `CHAR_W'(entry.count);
      if (upper)
        sym = sym - `CHAR_W'(8'h20);
    end else begin
      // punctuation keys ignore shift
      case (entry.key)
        KEY_1:    sym = pick_sym(SYMS_1, entry.count);
        KEY_STAR: sym = pick_sym(SYMS_STAR, entry.count);
        KEY_0:    sym = pick_sym(SYMS_0, entry.count);
        default:  sym = `SPACE_CHAR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msg         <= {`MSG_CHARS{`SPACE_CHAR}};
      msg_tx_ctrl <= 1'b0;
    end else begin
      msg_tx_ctrl <= 1'b0;
      if (entry.valid) begin
        case (entry.op)
          // new character enters at the low byte, oldest drops off the top
          OP_CHAR:   msg <= {msg[MSG_W-`CHAR_W-1:0], sym};
          OP_SPACE:  msg <= {msg[MSG_W-`CHAR_W-1:0], `SPACE_CHAR};
          // delete pulls everything back down, space fills the top
          OP_DELETE: msg <= {`SPACE_CHAR, msg[MSG_W-1:`CHAR_W]};
          OP_SEND:   msg_tx_ctrl <= 1'b1;
          default:   msg <= msg;
        endcase
      end
    end
  end

endmodule

//--- design/keypad_control.sv
`timescale 1ns/1ps
`include "keypad_params.svh"

module keypad_control
  import keypad_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`KP_ROWS-1:0] readrow,
  output logic [`KP_COLS-1:0] scancol,
  output msg_t                msg_1,
  output logic                msg_tx_ctrl
);

  logic      key_press;
  key_code_t key_code;
  logic      letter_mode;
  logic      upper;

  // committed characters and commands toward the buffer
  key_entry_if entry ();

  keypad_scanner u_scanner (
    .clk       (clk),
    .rst_n     (rst_n),
    .readrow   (readrow),
    .scancol   (scancol),
    .key_press (key_press),
    .key_code  (key_code)
  );

  // mode flags and multi-tap state both watch the same press strobe
  mode_control u_mode (
    .clk         (clk),
    .rst_n       (rst_n),
    .key_press   (key_press),
    .key_code    (key_code),
    .letter_mode (letter_mode),
    .upper       (upper)
  );

  tap_tracker u_tap (
    .clk         (clk),
    .rst_n       (rst_n),
    .key_press   (key_press),
    .key_code    (key_code),
    .letter_mode (letter_mode),
    .entry       (entry.source)
  );

  message_assembler u_asm (
    .clk         (clk),
    .rst_n       (rst_n),
    .letter_mode (letter_mode),
    .upper       (upper),
    .entry       (entry.sink),
    .msg         (msg_1),
    .msg_tx_ctrl (msg_tx_ctrl)
  );

endmodule

//--- verif/keypad_control_tb.sv
`timescale 1ns/1ps
`include "keypad_params.svh"

module keypad_control_tb
  import keypad_pkg::*;
();

  localparam int SWEEP      = `KP_SCAN_DWELL * `KP_COLS;
  localparam int WAIT_LIMIT = 8 * SWEEP;
  localparam int MSG_BITS   = `MSG_CHARS * `CHAR_W;
  localparam key_code_t DIGIT_KEYS [10] = '{
    KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9
  };

  logic                clk;
  logic                rst_n;
  logic [`KP_ROWS-1:0] readrow;
  logic [`KP_COLS-1:0] scancol;
  msg_t                msg_1;
  logic                msg_tx_ctrl;

  // keypad model state
  key_code_t   held_key;
  logic        key_down;
  // reference message, newest character in the low byte
  msg_t        model_msg;
  logic [31:0] lfsr_state;
  int          check_count;
  int          fail_count;
  int          timeout_count;
  int          tx_cycles;

  keypad_control uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .readrow     (readrow),
    .scancol     (scancol),
    .msg_1       (msg_1),
    .msg_tx_ctrl (msg_tx_ctrl)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // held key closes its row only while its column is driven
  always @(negedge clk) begin
    if (key_down && scancol == held_key.col)
      readrow <= held_key.row;
    else
      readrow <= '0;
  end

  // every high cycle of the send strobe, for the end-of-run count
  always @(negedge clk) begin
    if (rst_n && msg_tx_ctrl)
      tx_cycles++;
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = v * 2 + int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [`CHAR_W-1:0] digit_char(int d);
    return `CHAR_W'(8'h30 + d);
  endfunction

  // new character enters at the low byte
  function automatic msg_t pushed(msg_t m, logic [`CHAR_W-1:0] ch);
    return {m[MSG_BITS-`CHAR_W-1:0], ch};
  endfunction

  // delete drops the newest character, space fills the top
  function automatic msg_t deleted(msg_t m);
    return {`SPACE_CHAR, m[MSG_BITS-1:`CHAR_W]};
  endfunction

  task automatic check_msg(msg_t got, msg_t exp, string what);
    check_count++;
    if (got !== exp) begin
      $display("FAIL at %0t: %s, got \"%s\" expected \"%s\"", $time, what, got, exp);
      fail_count++;
    end
  endtask

  task automatic check_tx(logic got, logic exp, string what);
    check_count++;
    if (got !== exp) begin
      $display("FAIL at %0t: %s, got %b expected %b", $time, what, got, exp);
      fail_count++;
    end
  endtask

  task automatic check_cols(logic [`KP_COLS-1:0] got, logic [`KP_COLS-1:0] exp, string what);
    check_count++;
    if (got !== exp) begin
      $display("FAIL at %0t: %s, got %b expected %b", $time, what, got, exp);
      fail_count++;
    end
  endtask

  // hold for four sweeps, then release for three
  task automatic press_key(key_code_t k);
    held_key = k;
    key_down = 1'b1;
    repeat (4 * SWEEP) @(negedge clk);
    key_down = 1'b0;
    repeat (3 * SWEEP) @(negedge clk);
  endtask

  task automatic wait_msg_change(msg_t prev);
    int n;
    n = 0;
    while (msg_1 == prev && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (msg_1 == prev) begin
      $display("ERROR at %0t: message never changed within %0d cycles", $time, WAIT_LIMIT);
      timeout_count++;
    end
  endtask

  // model_msg already holds the expected result of this key
  task automatic press_and_check(key_code_t k, string what);
    msg_t prev;
    prev = msg_1;
    press_key(k);
    if (model_msg != prev)
      wait_msg_change(prev);
    check_msg(msg_1, model_msg, what);
  endtask

  task automatic test_reset();
    logic [`KP_COLS-1:0] seen;
    seen = '0;
    check_msg(msg_1, model_msg, "message after reset");
    check_tx(msg_tx_ctrl, 1'b0, "send strobe after reset");
    for (int i = 0; i < SWEEP; i++) begin
      @(negedge clk);
      check_tx(logic'($onehot(scancol)), 1'b1, "scancol one-hot");
      seen = seen | scancol;
    end
    check_cols(seen, '1, "columns visited in one sweep");
  endtask

  // two rounds of eight random digits, then * and #, so old ones fall off
  task automatic test_number_mode();
    int d;
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 8; i++) begin
        rand_bits(4, d);
        d = d % 10;
        model_msg = pushed(model_msg, digit_char(d));
        press_and_check(DIGIT_KEYS[d], "number mode digit");
      end
      model_msg = pushed(model_msg, "*");
      press_and_check(KEY_STAR, "number mode star");
      model_msg = pushed(model_msg, "#");
      press_and_check(KEY_HASH, "number mode hash");
    end
  endtask

  task automatic test_multi_tap();
    // pending w is lost on the mode change, so C finds nothing
    press_and_check(KEY_B, "enter letter mode");
    press_and_check(KEY_9, "tap on 9");
    press_and_check(KEY_B, "leave letter mode with w pending");
    model_msg = pushed(model_msg, " ");
    press_and_check(KEY_C, "C after discarded letter");
    press_and_check(KEY_B, "enter letter mode");
    press_and_check(KEY_2, "first tap on 2");
    press_and_check(KEY_2, "second tap on 2");
    model_msg = pushed(model_msg, "b");
    press_and_check(KEY_C, "confirm b");
    // five taps on a four-symbol key wrap back to p
    repeat (5) press_and_check(KEY_7, "tap on 7");
    model_msg = pushed(model_msg, "p");
    press_and_check(KEY_C, "confirm wrapped p");
    press_and_check(KEY_4, "tap on 4");
    model_msg = pushed(model_msg, "g");
    press_and_check(KEY_5, "key change commits g");
    model_msg = pushed(model_msg, "j");
    press_and_check(KEY_C, "confirm j");
    press_and_check(KEY_B, "back to number mode");
  endtask

  task automatic test_shift();
    press_and_check(KEY_B, "enter letter mode");
    press_and_check(KEY_HASH, "shift on");
    press_and_check(KEY_3, "first tap on 3");
    press_and_check(KEY_3, "second tap on 3");
    model_msg = pushed(model_msg, "E");
    press_and_check(KEY_C, "confirm capital E");
    press_and_check(KEY_HASH, "shift off");
    press_and_check(KEY_3, "tap on 3");
    model_msg = pushed(model_msg, "d");
    press_and_check(KEY_C, "confirm lower d");
    // shift set, then two mode changes must clear it
    press_and_check(KEY_HASH, "shift on again");
    press_and_check(KEY_B, "number mode clears shift");
    model_msg = pushed(model_msg, "#");
    press_and_check(KEY_HASH, "hash in number mode");
    press_and_check(KEY_B, "letter mode again");
    press_and_check(KEY_2, "tap on 2");
    model_msg = pushed(model_msg, "a");
    press_and_check(KEY_C, "letter stays lower case");
    press_and_check(KEY_B, "back to number mode");
  endtask

  task automatic test_space_delete();
    model_msg = pushed(model_msg, " ");
    press_and_check(KEY_C, "space with nothing pending");
    model_msg = pushed(model_msg, "5");
    press_and_check(KEY_5, "digit before delete");
    model_msg = deleted(model_msg);
    press_and_check(KEY_A, "first delete");
    model_msg = deleted(model_msg);
    press_and_check(KEY_A, "second delete");
  endtask

  task automatic test_send();
    msg_t prev;
    int   n;
    prev     = msg_1;
    n        = 0;
    held_key = KEY_D;
    key_down = 1'b1;
    while (!msg_tx_ctrl && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!msg_tx_ctrl) begin
      $display("ERROR at %0t: send strobe never rose after pressing D", $time);
      timeout_count++;
    end else begin
      check_msg(msg_1, prev, "message during send");
      @(negedge clk);
      check_tx(msg_tx_ctrl, 1'b0, "send strobe one cycle wide");
    end
    key_down = 1'b0;
    repeat (3 * SWEEP) @(negedge clk);
    check_msg(msg_1, model_msg, "message after send");
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    readrow       = '0;
    held_key      = KEY_1;
    key_down      = 1'b0;
    model_msg     = {`MSG_CHARS{`SPACE_CHAR}};
    lfsr_state    = 32'h3bac724a;
    check_count   = 0;
    fail_count    = 0;
    timeout_count = 0;
    tx_cycles     = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_number_mode();
    test_multi_tap();
    test_shift();
    test_space_delete();
    test_send();
    // exactly one strobe cycle, from the single D press
    check_tx(logic'(tx_cycles == 1), 1'b1, "send strobe cycles over the run");
    $display("checks: %0d, value errors: %0d, timeouts: %0d",
             check_count, fail_count, timeout_count);
    if (fail_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- keypad_control.f
+incdir+design
design/keypad_pkg.sv
design/key_entry_if.sv
design/keypad_scanner.sv
design/mode_control.sv
design/tap_tracker.sv
design/message_assembler.sv
design/keypad_control.sv
verif/keypad_control_tb.sv

//--- Makefile
TB_TOP = keypad_control_tb

all: run

run:
	verilator --binary --timing -f keypad_control.f --top-module $(TB_TOP) -o sim
	./obj_dir/sim > sim.log 2>&1
	cat sim.log
	! grep -qF "*** FAILED ***" sim.log

lint:
	verilator --lint-only --timing -f keypad_control.f --top-module keypad_control

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
